// ==== hdl/kern_defines.svh ====
`ifndef KERN_DEFINES_SVH
`define KERN_DEFINES_SVH

// Kernel sizing
`define KERN_NUM_CHANNELS 4
`define KERN_MEM_DEPTH 16
`define KERN_MEM_AW 4

// Control register offsets
`define KERN_CFG 8'h00
`define KERN_CHANNEL_AVAIL 8'h04
`define KERN_CHNL_SEL 8'h0C
`define KERN_AXLEN 8'h10
`define KERN_WDATA_PATTERN 8'h14
`define KERN_WR_CTL 8'h18
`define KERN_RD_CTL 8'h1C

// Write statistics offsets
`define KERN_WR_DONE_CNT_LO 8'h30
`define KERN_WR_DONE_CNT_HI 8'h34
`define KERN_WR_TIMER_LO 8'h38
`define KERN_WR_TIMER_HI 8'h3C
`define KERN_WR_LATENCY 8'h40
`define KERN_WR_OT 8'h44
`define KERN_BRESP_ERR 8'h48

// Read statistics offsets
`define KERN_RD_DONE_CNT_LO 8'h50
`define KERN_RD_DONE_CNT_HI 8'h54
`define KERN_RD_TIMER_LO 8'h58
`define KERN_RD_TIMER_HI 8'h5C
`define KERN_RD_LATENCY 8'h60
`define KERN_RD_OT 8'h64
`define KERN_RRESP_ERR 8'h68

// Returned for any unmapped offset
`define KERN_BAD_ADDR_DATA 32'hBAAD_DEC0

`endif

// ==== hdl/kern_pkg.sv ====
`include "kern_defines.svh"

package kern_pkg;

   // ============================================================
   // Configuration bus
   // ============================================================

   // Host request, strobes are levels held until ack
   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] wdata;
      logic        wr;
      logic        rd;
   } cfg_req_t;

   // Slave response, rdata valid while ack is high
   typedef struct packed {
      logic [31:0] rdata;
      logic        ack;
   } cfg_rsp_t;

   // ============================================================
   // Engine control and status
   // ============================================================

   // Broadcast from the register block to every channel
   typedef struct packed {
      logic [`KERN_NUM_CHANNELS-1:0] wr_start;
      logic [`KERN_NUM_CHANNELS-1:0] rd_start;
      logic [31:0]                   axlen;
      logic [31:0]                   pattern;
   } chan_ctl_t;

   // Per-cycle report of one engine
   typedef struct packed {
      logic        done;
      logic        err;
      logic [15:0] pend;
   } eng_stat_t;

endpackage

// ==== hdl/pipe_delay.sv ====
module pipe_delay #(
   parameter int WIDTH  = 8,
   parameter int STAGES = 3
) (
   input  logic             clk_main_a0,
   input  logic             rst_main_a0,
   input  logic [WIDTH-1:0] i_data,
   output logic [WIDTH-1:0] o_data
);

   // Shift chain, stage 0 takes the input
   logic [WIDTH-1:0] stage_q [STAGES];

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_a0) begin
         for (int ii = 0; ii < STAGES; ii++) begin
            stage_q[ii] <= '0;
         end
      end else begin
         stage_q[0] <= i_data;
         for (int ii = 1; ii < STAGES; ii++) begin
            stage_q[ii] <= stage_q[ii-1];
         end
      end
   end

   // Oldest stage drives the output
   assign o_data = stage_q[STAGES-1];

endmodule

// ==== hdl/scratch_mem.sv ====
`include "kern_defines.svh"

module scratch_mem (
   input  logic                    clk_main_a0,
   input  logic                    i_we,
   input  logic [`KERN_MEM_AW-1:0] i_waddr,
   input  logic [31:0]             i_wdata,
   input  logic                    i_re,
   input  logic [`KERN_MEM_AW-1:0] i_raddr,
   output logic [31:0]             o_rdata
);

   // Word storage for one channel
   logic [31:0] mem [`KERN_MEM_DEPTH];

   // Write port
   always_ff @(posedge clk_main_a0) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   // Read port, data appears the cycle after the address
   always_ff @(posedge clk_main_a0) begin
      if (i_re) begin
         o_rdata <= mem[i_raddr];
      end
   end

endmodule

// ==== hdl/wr_engine.sv ====
`include "kern_defines.svh"

module wr_engine import kern_pkg::*; (
   input  logic                    clk_main_a0,
   input  logic                    rst_main_a0,
   input  logic                    i_start,
   input  logic [31:0]             i_axlen,
   input  logic [31:0]             i_pattern,
   output logic                    o_mem_we,
   output logic [`KERN_MEM_AW-1:0] o_mem_addr,
   output logic [31:0]             o_mem_wdata,
   output eng_stat_t               o_stat
);

   logic        start_q;
   logic        busy_q;
   logic [15:0] beat_q;
   logic [15:0] rem_q;
   logic        in_range;

   // Burst state, a new start is ignored while busy
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_a0) begin
         start_q <= 1'b0;
         busy_q  <= 1'b0;
         beat_q  <= '0;
         rem_q   <= '0;
      end else begin
         start_q <= i_start;
         if (i_start && !start_q && !busy_q) begin
            busy_q <= 1'b1;
            beat_q <= '0;
            rem_q  <= i_axlen[15:0] + 16'd1;
         end else if (busy_q) begin
            beat_q <= beat_q + 16'd1;
            rem_q  <= rem_q - 16'd1;
            // Last beat goes out this cycle
            if (rem_q == 16'd1) begin
               busy_q <= 1'b0;
            end
         end
      end
   end

   // Beats past the end of memory are dropped
   assign in_range = (beat_q < 16'(`KERN_MEM_DEPTH));

   // One beat per busy cycle
   assign o_mem_we    = busy_q & in_range;
   assign o_mem_addr  = beat_q[`KERN_MEM_AW-1:0];
   assign o_mem_wdata = i_pattern + 32'(beat_q);

   assign o_stat.done = busy_q && (rem_q == 16'd1);
   assign o_stat.err  = busy_q & ~in_range;
   assign o_stat.pend = rem_q;

endmodule

// ==== hdl/rd_engine.sv ====
`include "kern_defines.svh"

module rd_engine import kern_pkg::*; (
   input  logic                    clk_main_a0,
   input  logic                    rst_main_a0,
   input  logic                    i_start,
   input  logic [31:0]             i_axlen,
   input  logic [31:0]             i_pattern,
   output logic                    o_mem_re,
   output logic [`KERN_MEM_AW-1:0] o_mem_addr,
   input  logic [31:0]             i_mem_rdata,
   output eng_stat_t               o_stat
);

   logic        start_q;
   logic        busy_q;
   logic        accept;
   logic [15:0] beat_q;
   logic [15:0] rem_q;
   logic        in_range;
   logic        cmp_q;
   logic        last_q;
   logic        oor_q;
   logic        bad_q;
   logic [15:0] exp_idx_q;
   logic        mismatch;

   assign accept   = i_start & ~start_q & ~busy_q;
   assign in_range = (beat_q < 16'(`KERN_MEM_DEPTH));

   // ============================================================
   // Issue stage
   // ============================================================
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_a0) begin
         start_q <= 1'b0;
         busy_q  <= 1'b0;
         beat_q  <= '0;
         rem_q   <= '0;
      end else begin
         start_q <= i_start;
         if (accept) begin
            busy_q <= 1'b1;
            beat_q <= '0;
            rem_q  <= i_axlen[15:0] + 16'd1;
         end else if (busy_q) begin
            beat_q <= beat_q + 16'd1;
            rem_q  <= rem_q - 16'd1;
            if (rem_q == 16'd1) begin
               busy_q <= 1'b0;
            end
         end
      end
   end

   // Out-of-range beats issue no read
   assign o_mem_re   = busy_q & in_range;
   assign o_mem_addr = beat_q[`KERN_MEM_AW-1:0];

   // ============================================================
   // Compare stage, lines up with the registered read data
   // ============================================================
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_a0) begin
         cmp_q  <= 1'b0;
         last_q <= 1'b0;
         oor_q  <= 1'b0;
         bad_q  <= 1'b0;
      end else begin
         cmp_q  <= busy_q;
         last_q <= busy_q && (rem_q == 16'd1);
         oor_q  <= busy_q & ~in_range;
         // Error summary is per burst
         if (accept) begin
            bad_q <= 1'b0;
         end else if (mismatch || oor_q) begin
            bad_q <= 1'b1;
         end
      end
   end

   // Beat index of the word now on the read data
   always_ff @(posedge clk_main_a0) begin
      exp_idx_q <= beat_q;
   end

   assign mismatch = cmp_q & ~oor_q & (i_mem_rdata != (i_pattern + 32'(exp_idx_q)));

   // Done one cycle after the last address
   assign o_stat.done = cmp_q & last_q;
   assign o_stat.err  = o_stat.done & (bad_q | mismatch | oor_q);
   // Beats still to issue plus the one being compared
   assign o_stat.pend = rem_q + 16'(cmp_q);

endmodule

// ==== hdl/kernel_regs.sv ====
`include "kern_defines.svh"

module kernel_regs import kern_pkg::*; (
   input  logic      clk_main_a0,
   input  logic      rst_main_a0,
   input  cfg_req_t  i_cfg_req,
   output cfg_rsp_t  o_cfg_rsp,
   output chan_ctl_t o_chan_ctl,
   input  eng_stat_t i_wr_stat [`KERN_NUM_CHANNELS],
   input  eng_stat_t i_rd_stat [`KERN_NUM_CHANNELS],
   output logic      o_kernel_enable
);

   localparam int NCH   = `KERN_NUM_CHANNELS;
   localparam int SUM_W = $clog2(NCH + 1);

   // ============================================================
   // Configuration bus slave
   // ============================================================
   logic        cfg_wr_q;
   logic        cfg_rd_q;
   logic        cfg_wr_pulse_q;
   logic        cfg_rd_pulse_q;
   logic [7:0]  cfg_addr_q;
   logic [31:0] cfg_wdata_q;
   logic [31:0] rdata_q;
   logic        ack_q;

   // Rising edge of either strobe, address and data sampled alongside
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_a0) begin
         cfg_wr_q       <= 1'b0;
         cfg_rd_q       <= 1'b0;
         cfg_wr_pulse_q <= 1'b0;
         cfg_rd_pulse_q <= 1'b0;
         ack_q          <= 1'b0;
      end else begin
         cfg_wr_q       <= i_cfg_req.wr;
         cfg_rd_q       <= i_cfg_req.rd;
         cfg_wr_pulse_q <= i_cfg_req.wr & ~cfg_wr_q;
         cfg_rd_pulse_q <= i_cfg_req.rd & ~cfg_rd_q;
         // Ack two clocks after the strobe rises
         ack_q          <= cfg_wr_pulse_q | cfg_rd_pulse_q;
      end
   end

   always_ff @(posedge clk_main_a0) begin
      cfg_addr_q  <= i_cfg_req.addr;
      cfg_wdata_q <= i_cfg_req.wdata;
   end

   assign o_cfg_rsp = '{rdata: rdata_q, ack: ack_q};

   // Zero write to a statistics register
   function automatic logic clr_hit(input logic [7:0] off);
      return cfg_wr_pulse_q && (cfg_addr_q == off) && (cfg_wdata_q == '0);
   endfunction

   // ============================================================
   // Control registers and start generation
   // ============================================================
   logic [31:0]    kern_cfg_reg;
   logic [31:0]    chnl_sel_reg;
   logic [31:0]    axlen_reg;
   logic [31:0]    pattern_reg;
   logic [31:0]    wr_ctl_reg;
   logic [31:0]    rd_ctl_reg;
   logic [NCH-1:0] wr_start_q;
   logic [NCH-1:0] rd_start_q;

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_a0) begin
         kern_cfg_reg <= '0;
         chnl_sel_reg <= '0;
         axlen_reg    <= '0;
         pattern_reg  <= '0;
         wr_ctl_reg   <= '0;
         rd_ctl_reg   <= '0;
         wr_start_q   <= '0;
         rd_start_q   <= '0;
      end else begin
         if (cfg_wr_pulse_q) begin
            case (cfg_addr_q)
               `KERN_CFG:           kern_cfg_reg <= cfg_wdata_q;
               `KERN_CHNL_SEL:      chnl_sel_reg <= cfg_wdata_q;
               `KERN_AXLEN:         axlen_reg    <= cfg_wdata_q;
               `KERN_WDATA_PATTERN: pattern_reg  <= cfg_wdata_q;
               `KERN_WR_CTL:        wr_ctl_reg   <= cfg_wdata_q;
               `KERN_RD_CTL:        rd_ctl_reg   <= cfg_wdata_q;
               default: ;
            endcase
         end
         // Masks only reach the engines while enabled
         wr_start_q <= wr_ctl_reg[NCH-1:0] & {NCH{kern_cfg_reg[0]}};
         rd_start_q <= rd_ctl_reg[NCH-1:0] & {NCH{kern_cfg_reg[0]}};
      end
   end

   assign o_kernel_enable = kern_cfg_reg[0];
   assign o_chan_ctl = '{wr_start: wr_start_q, rd_start: rd_start_q,
                         axlen: axlen_reg, pattern: pattern_reg};

   // ============================================================
   // Per-channel gathering
   // ============================================================
   logic [SUM_W-1:0] wr_done_sum;
   logic [SUM_W-1:0] rd_done_sum;
   logic [NCH-1:0]   wr_busy;
   logic [NCH-1:0]   rd_busy;
   logic [NCH-1:0]   wr_err;
   logic [NCH-1:0]   rd_err;
   logic             sel_wr_start;
   logic             sel_rd_start;
   logic             sel_wr_done;
   logic             sel_rd_done;
   logic [15:0]      sel_wr_pend;
   logic [15:0]      sel_rd_pend;

   always_comb begin
      wr_done_sum  = '0;
      rd_done_sum  = '0;
      sel_wr_start = 1'b0;
      sel_rd_start = 1'b0;
      sel_wr_done  = 1'b0;
      sel_rd_done  = 1'b0;
      sel_wr_pend  = '0;
      sel_rd_pend  = '0;
      for (int ii = 0; ii < NCH; ii++) begin
         // Done pulses of all channels in this cycle
         wr_done_sum = wr_done_sum + SUM_W'(i_wr_stat[ii].done);
         rd_done_sum = rd_done_sum + SUM_W'(i_rd_stat[ii].done);
         wr_busy[ii] = (i_wr_stat[ii].pend != '0);
         rd_busy[ii] = (i_rd_stat[ii].pend != '0);
         wr_err[ii]  = i_wr_stat[ii].err;
         rd_err[ii]  = i_rd_stat[ii].err;
         // Channel picked by CHNL_SEL
         if (chnl_sel_reg == 32'(ii)) begin
            sel_wr_start = wr_start_q[ii];
            sel_rd_start = rd_start_q[ii];
            sel_wr_done  = i_wr_stat[ii].done;
            sel_rd_done  = i_rd_stat[ii].done;
            sel_wr_pend  = i_wr_stat[ii].pend;
            sel_rd_pend  = i_rd_stat[ii].pend;
         end
      end
   end

   // Retimed statistics inputs
   logic [SUM_W-1:0] wr_done_dly;
   logic [SUM_W-1:0] rd_done_dly;
   logic [NCH-1:0]   wr_busy_dly;
   logic [NCH-1:0]   rd_busy_dly;

   pipe_delay #(.WIDTH(SUM_W), .STAGES(3)) u_wr_done_dly (
      .clk_main_a0 (clk_main_a0),
      .rst_main_a0 (rst_main_a0),
      .i_data      (wr_done_sum),
      .o_data      (wr_done_dly)
   );

   pipe_delay #(.WIDTH(SUM_W), .STAGES(3)) u_rd_done_dly (
      .clk_main_a0 (clk_main_a0),
      .rst_main_a0 (rst_main_a0),
      .i_data      (rd_done_sum),
      .o_data      (rd_done_dly)
   );

   pipe_delay #(.WIDTH(NCH), .STAGES(3)) u_wr_busy_dly (
      .clk_main_a0 (clk_main_a0),
      .rst_main_a0 (rst_main_a0),
      .i_data      (wr_busy),
      .o_data      (wr_busy_dly)
   );

   pipe_delay #(.WIDTH(NCH), .STAGES(3)) u_rd_busy_dly (
      .clk_main_a0 (clk_main_a0),
      .rst_main_a0 (rst_main_a0),
      .i_data      (rd_busy),
      .o_data      (rd_busy_dly)
   );

   // ============================================================
   // Statistics counters
   // ============================================================
   logic [63:0]    wr_done_cnt_q;
   logic [63:0]    rd_done_cnt_q;
   logic [63:0]    wr_timer_q;
   logic [63:0]    rd_timer_q;
   logic [31:0]    wr_lat_q;
   logic [31:0]    rd_lat_q;
   logic [31:0]    wr_ot_q;
   logic [31:0]    rd_ot_q;
   logic [31:0]    bresp_err_q;
   logic [31:0]    rresp_err_q;
   logic [NCH-1:0] wr_err_q;
   logic [NCH-1:0] rd_err_q;
   logic           sel_wr_start_q;
   logic           sel_rd_start_q;
   logic           wr_lat_act_q;
   logic           rd_lat_act_q;

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_a0) begin
         wr_done_cnt_q  <= '0;
         rd_done_cnt_q  <= '0;
         wr_timer_q     <= '0;
         rd_timer_q     <= '0;
         wr_lat_q       <= '0;
         rd_lat_q       <= '0;
         wr_ot_q        <= '0;
         rd_ot_q        <= '0;
         bresp_err_q    <= '0;
         rresp_err_q    <= '0;
         wr_err_q       <= '0;
         rd_err_q       <= '0;
         sel_wr_start_q <= 1'b0;
         sel_rd_start_q <= 1'b0;
         wr_lat_act_q   <= 1'b0;
         rd_lat_act_q   <= 1'b0;
      end else begin
         // Completed bursts, all channels
         if (clr_hit(`KERN_WR_DONE_CNT_LO) || clr_hit(`KERN_WR_DONE_CNT_HI))
            wr_done_cnt_q <= '0;
         else
            wr_done_cnt_q <= wr_done_cnt_q + 64'(wr_done_dly);
         if (clr_hit(`KERN_RD_DONE_CNT_LO) || clr_hit(`KERN_RD_DONE_CNT_HI))
            rd_done_cnt_q <= '0;
         else
            rd_done_cnt_q <= rd_done_cnt_q + 64'(rd_done_dly);

         // Busy time while any start bit or pending beat is seen
         if (clr_hit(`KERN_WR_TIMER_LO) || clr_hit(`KERN_WR_TIMER_HI))
            wr_timer_q <= '0;
         else if ((|wr_start_q) || (|wr_busy_dly))
            wr_timer_q <= wr_timer_q + 64'd1;
         if (clr_hit(`KERN_RD_TIMER_LO) || clr_hit(`KERN_RD_TIMER_HI))
            rd_timer_q <= '0;
         else if ((|rd_start_q) || (|rd_busy_dly))
            rd_timer_q <= rd_timer_q + 64'd1;

         // Selected channel window from start edge to done
         sel_wr_start_q <= sel_wr_start;
         sel_rd_start_q <= sel_rd_start;
         if (sel_wr_done)
            wr_lat_act_q <= 1'b0;
         else if (sel_wr_start && !sel_wr_start_q)
            wr_lat_act_q <= 1'b1;
         if (sel_rd_done)
            rd_lat_act_q <= 1'b0;
         else if (sel_rd_start && !sel_rd_start_q)
            rd_lat_act_q <= 1'b1;

         if (clr_hit(`KERN_WR_LATENCY))
            wr_lat_q <= '0;
         else if (wr_lat_act_q)
            wr_lat_q <= wr_lat_q + 32'd1;
         if (clr_hit(`KERN_RD_LATENCY))
            rd_lat_q <= '0;
         else if (rd_lat_act_q)
            rd_lat_q <= rd_lat_q + 32'd1;

         // Outstanding beats of the selected channel
         wr_ot_q <= 32'(sel_wr_pend);
         rd_ot_q <= 32'(sel_rd_pend);

         // Errors flopped once, then sticky per channel
         wr_err_q <= wr_err;
         rd_err_q <= rd_err;
         if (clr_hit(`KERN_BRESP_ERR))
            bresp_err_q <= '0;
         else
            bresp_err_q <= bresp_err_q | 32'(wr_err_q);
         if (clr_hit(`KERN_RRESP_ERR))
            rresp_err_q <= '0;
         else
            rresp_err_q <= rresp_err_q | 32'(rd_err_q);
      end
   end

   // ============================================================
   // Read data mux
   // ============================================================
   always_ff @(posedge clk_main_a0) begin
      case (cfg_addr_q)
         `KERN_CFG:            rdata_q <= kern_cfg_reg;
         `KERN_CHANNEL_AVAIL:  rdata_q <= 32'(NCH);
         `KERN_CHNL_SEL:       rdata_q <= chnl_sel_reg;
         `KERN_AXLEN:          rdata_q <= axlen_reg;
         `KERN_WDATA_PATTERN:  rdata_q <= pattern_reg;
         `KERN_WR_CTL:         rdata_q <= wr_ctl_reg;
         `KERN_RD_CTL:         rdata_q <= rd_ctl_reg;
         `KERN_WR_DONE_CNT_LO: rdata_q <= wr_done_cnt_q[31:0];
         `KERN_WR_DONE_CNT_HI: rdata_q <= wr_done_cnt_q[63:32];
         `KERN_WR_TIMER_LO:    rdata_q <= wr_timer_q[31:0];
         `KERN_WR_TIMER_HI:    rdata_q <= wr_timer_q[63:32];
         `KERN_WR_LATENCY:     rdata_q <= wr_lat_q;
         `KERN_WR_OT:          rdata_q <= wr_ot_q;
         `KERN_BRESP_ERR:      rdata_q <= bresp_err_q;
         `KERN_RD_DONE_CNT_LO: rdata_q <= rd_done_cnt_q[31:0];
         `KERN_RD_DONE_CNT_HI: rdata_q <= rd_done_cnt_q[63:32];
         `KERN_RD_TIMER_LO:    rdata_q <= rd_timer_q[31:0];
         `KERN_RD_TIMER_HI:    rdata_q <= rd_timer_q[63:32];
         `KERN_RD_LATENCY:     rdata_q <= rd_lat_q;
         `KERN_RD_OT:          rdata_q <= rd_ot_q;
         `KERN_RRESP_ERR:      rdata_q <= rresp_err_q;
         default:              rdata_q <= `KERN_BAD_ADDR_DATA;
      endcase
   end

endmodule

// ==== hdl/kernel_top.sv ====
`include "kern_defines.svh"

module kernel_top import kern_pkg::*; (
   input  logic     clk_main_a0,
   input  logic     rst_main_a0,
   input  cfg_req_t i_cfg_req,
   output cfg_rsp_t o_cfg_rsp,
   output logic     o_kernel_enable
);

   chan_ctl_t chan_ctl;
   eng_stat_t wr_stat [`KERN_NUM_CHANNELS];
   eng_stat_t rd_stat [`KERN_NUM_CHANNELS];

   // ============================================================
   // Register block
   // ============================================================
   kernel_regs u_regs (
      .clk_main_a0     (clk_main_a0),
      .rst_main_a0     (rst_main_a0),
      .i_cfg_req       (i_cfg_req),
      .o_cfg_rsp       (o_cfg_rsp),
      .o_chan_ctl      (chan_ctl),
      .i_wr_stat       (wr_stat),
      .i_rd_stat       (rd_stat),
      .o_kernel_enable (o_kernel_enable)
   );

   // ============================================================
   // Channels, each an engine pair on a private memory
   // ============================================================
   for (genvar gi = 0; gi < `KERN_NUM_CHANNELS; gi++) begin : g_chan
      logic                    mem_we;
      logic                    mem_re;
      logic [`KERN_MEM_AW-1:0] mem_waddr;
      logic [`KERN_MEM_AW-1:0] mem_raddr;
      logic [31:0]             mem_wdata;
      logic [31:0]             mem_rdata;

      wr_engine u_wr (
         .clk_main_a0 (clk_main_a0),
         .rst_main_a0 (rst_main_a0),
         .i_start     (chan_ctl.wr_start[gi]),
         .i_axlen     (chan_ctl.axlen),
         .i_pattern   (chan_ctl.pattern),
         .o_mem_we    (mem_we),
         .o_mem_addr  (mem_waddr),
         .o_mem_wdata (mem_wdata),
         .o_stat      (wr_stat[gi])
      );

      rd_engine u_rd (
         .clk_main_a0 (clk_main_a0),
         .rst_main_a0 (rst_main_a0),
         .i_start     (chan_ctl.rd_start[gi]),
         .i_axlen     (chan_ctl.axlen),
         .i_pattern   (chan_ctl.pattern),
         .o_mem_re    (mem_re),
         .o_mem_addr  (mem_raddr),
         .i_mem_rdata (mem_rdata),
         .o_stat      (rd_stat[gi])
      );

      scratch_mem u_mem (
         .clk_main_a0 (clk_main_a0),
         .i_we        (mem_we),
         .i_waddr     (mem_waddr),
         .i_wdata     (mem_wdata),
         .i_re        (mem_re),
         .i_raddr     (mem_raddr),
         .o_rdata     (mem_rdata)
      );
   end

endmodule

// ==== testbench/tb_cfg_tasks.svh ====
`ifndef TB_CFG_TASKS_SVH
`define TB_CFG_TASKS_SVH

// ============================================================
// Configuration bus host and checking
// ============================================================

// Compare one value against its expected value, stop on the first mismatch
task automatic compare_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
   if (got !== exp) begin
      $display("Fail %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first mismatch");
   end
endtask

// Poll ack once per cycle, just after the edge where it is stable
task automatic wait_ack(output logic [31:0] rdata);
   int cycles;
   cycles = 0;
   do begin
      @(posedge clk_main_a0);
      #1;
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
         $display("Timeout: no ack on the configuration bus within %0d cycles", ACK_TIMEOUT);
         $display("Some tests failed");
         $fatal(1, "Configuration bus did not answer");
      end
   end while (!cfg_rsp.ack);
   // rdata only valid while ack is high
   rdata = cfg_rsp.rdata;
endtask

// Register write, strobe held until ack
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
   logic [31:0] ack_rdata;
   @(posedge clk_main_a0);
   #1;
   cfg_req.addr  = addr;
   cfg_req.wdata = data;
   cfg_req.wr    = 1'b1;
   wait_ack(ack_rdata);
   cfg_req.wr = 1'b0;
   // Strobe low across at least one edge
   @(posedge clk_main_a0);
   #1;
endtask

// Register read
task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata);
   @(posedge clk_main_a0);
   #1;
   cfg_req.addr  = addr;
   cfg_req.wdata = 32'h0;
   cfg_req.rd    = 1'b1;
   wait_ack(rdata);
   cfg_req.rd = 1'b0;
   @(posedge clk_main_a0);
   #1;
endtask

// Let the engines run with the bus quiet
task automatic idle_cycles(input int n);
   repeat (n) @(posedge clk_main_a0);
   #1;
endtask

`endif

// ==== testbench/tb_kernel_top.sv ====
`include "kern_defines.svh"

module tb_kernel_top import kern_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          ACK_TIMEOUT = 16;
   localparam logic [31:0] FULL        = 32'hFFFF_FFFF;
   localparam logic [31:0] PAT_A       = 32'hA5A5_1000;
   localparam logic [31:0] PAT_B       = 32'h5A5A_2000;

   // One row of the stimulus table
   typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_NONZERO, OP_IDLE} row_op_e;
   typedef struct packed {
      row_op_e     op;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [31:0] exp;
      logic [31:0] mask;
   } row_t;

   logic     clk_main_a0;
   logic     rst_main_a0;
   cfg_req_t cfg_req;
   cfg_rsp_t cfg_rsp;
   logic     kernel_enable;
   row_t     rows [$];
   // Expected level of the enable output, bit 0 of the last config write
   logic     exp_enable;

   kernel_top uut (
      .clk_main_a0     (clk_main_a0),
      .rst_main_a0     (rst_main_a0),
      .i_cfg_req       (cfg_req),
      .o_cfg_rsp       (cfg_rsp),
      .o_kernel_enable (kernel_enable)
   );

   `include "tb_cfg_tasks.svh"

   // 4 ns clock
   initial begin
      clk_main_a0 = 1'b0;
      forever #2 clk_main_a0 = ~clk_main_a0;
   end

   // ============================================================
   // Stimulus table
   // ============================================================
   function automatic void write_row(input logic [7:0] addr, input logic [31:0] data);
      rows.push_back('{op: OP_WRITE, addr: addr, data: data, exp: 32'h0, mask: 32'h0});
   endfunction

   function automatic void read_row(input logic [7:0] addr, input logic [31:0] exp,
                                    input logic [31:0] mask);
      rows.push_back('{op: OP_READ, addr: addr, data: 32'h0, exp: exp, mask: mask});
   endfunction

   // Free-running values, only checked for activity
   function automatic void nonzero_row(input logic [7:0] addr);
      rows.push_back('{op: OP_NONZERO, addr: addr, data: 32'h0, exp: 32'h0, mask: FULL});
   endfunction

   function automatic void idle_row(input int n);
      rows.push_back('{op: OP_IDLE, addr: 8'h0, data: 32'(n), exp: 32'h0, mask: 32'h0});
   endfunction

   task automatic build_table();
      logic [7:0] zero_regs [20];
      zero_regs = '{`KERN_CFG, `KERN_CHNL_SEL, `KERN_AXLEN, `KERN_WDATA_PATTERN,
                    `KERN_WR_CTL, `KERN_RD_CTL, `KERN_WR_DONE_CNT_LO, `KERN_WR_DONE_CNT_HI,
                    `KERN_WR_TIMER_LO, `KERN_WR_TIMER_HI, `KERN_WR_LATENCY, `KERN_WR_OT,
                    `KERN_BRESP_ERR, `KERN_RD_DONE_CNT_LO, `KERN_RD_DONE_CNT_HI,
                    `KERN_RD_TIMER_LO, `KERN_RD_TIMER_HI, `KERN_RD_LATENCY, `KERN_RD_OT,
                    `KERN_RRESP_ERR};
      // Reset values and decode
      foreach (zero_regs[ii]) read_row(zero_regs[ii], 32'h0, FULL);
      read_row(`KERN_CHANNEL_AVAIL, 32'd4, FULL);
      read_row(8'h08, `KERN_BAD_ADDR_DATA, FULL);
      read_row(8'h2C, `KERN_BAD_ADDR_DATA, FULL);
      read_row(8'h70, `KERN_BAD_ADDR_DATA, FULL);
      read_row(8'hFF, `KERN_BAD_ADDR_DATA, FULL);
      // Control readback
      write_row(`KERN_CFG, 32'h1);
      write_row(`KERN_AXLEN, 32'd7);
      write_row(`KERN_WDATA_PATTERN, PAT_A);
      write_row(`KERN_CHNL_SEL, 32'd2);
      read_row(`KERN_CFG, 32'h1, FULL);
      read_row(`KERN_AXLEN, 32'd7, FULL);
      read_row(`KERN_WDATA_PATTERN, PAT_A, FULL);
      read_row(`KERN_CHNL_SEL, 32'd2, FULL);
      write_row(`KERN_CHNL_SEL, 32'd0);
      read_row(`KERN_CHNL_SEL, 32'd0, FULL);
      // 8-beat write bursts on channels 0 and 2
      write_row(`KERN_WR_CTL, 32'h5);
      idle_row(40);
      read_row(`KERN_WR_DONE_CNT_LO, 32'd2, FULL);
      read_row(`KERN_WR_DONE_CNT_HI, 32'd0, FULL);
      read_row(`KERN_BRESP_ERR, 32'h0, FULL);
      read_row(`KERN_WR_LATENCY, 32'd8, FULL);
      read_row(`KERN_WR_OT, 32'd0, FULL);
      nonzero_row(`KERN_WR_TIMER_LO);
      // Read back with the same pattern
      write_row(`KERN_WR_CTL, 32'h0);
      write_row(`KERN_RD_CTL, 32'h5);
      idle_row(40);
      read_row(`KERN_RD_DONE_CNT_LO, 32'd2, FULL);
      read_row(`KERN_RRESP_ERR, 32'h0, FULL);
      read_row(`KERN_RD_LATENCY, 32'd9, FULL);
      read_row(`KERN_RD_OT, 32'd0, FULL);
      nonzero_row(`KERN_RD_TIMER_LO);
      // Every word mismatches against another pattern
      write_row(`KERN_RD_CTL, 32'h0);
      write_row(`KERN_WDATA_PATTERN, PAT_B);
      write_row(`KERN_RD_CTL, 32'h5);
      idle_row(40);
      read_row(`KERN_RD_DONE_CNT_LO, 32'd4, FULL);
      read_row(`KERN_RRESP_ERR, 32'h5, FULL);
      // 21 beats on channel 1, the last five fall off the memory
      write_row(`KERN_AXLEN, 32'd20);
      write_row(`KERN_WR_CTL, 32'h2);
      idle_row(60);
      read_row(`KERN_BRESP_ERR, 32'h2, 32'h0000_000F);
      read_row(`KERN_WR_DONE_CNT_LO, 32'd3, FULL);
      read_row(`KERN_WR_LATENCY, 32'd8, FULL);
      write_row(`KERN_BRESP_ERR, 32'h0);
      read_row(`KERN_BRESP_ERR, 32'h0, FULL);
      // Masks set again while disabled
      write_row(`KERN_WR_CTL, 32'h0);
      write_row(`KERN_RD_CTL, 32'h0);
      idle_row(4);
      write_row(`KERN_CFG, 32'h0);
      write_row(`KERN_WR_CTL, 32'h5);
      write_row(`KERN_RD_CTL, 32'h5);
      idle_row(40);
      read_row(`KERN_CFG, 32'h0, FULL);
      read_row(`KERN_WR_DONE_CNT_LO, 32'd3, FULL);
      read_row(`KERN_RD_DONE_CNT_LO, 32'd4, FULL);
      read_row(`KERN_BRESP_ERR, 32'h0, FULL);
      // Zero writes clear the statistics, HI offsets clear the full counter
      write_row(`KERN_WR_DONE_CNT_LO, 32'h0);
      write_row(`KERN_RD_DONE_CNT_HI, 32'h0);
      write_row(`KERN_WR_TIMER_LO, 32'h0);
      write_row(`KERN_RD_TIMER_HI, 32'h0);
      write_row(`KERN_WR_LATENCY, 32'h0);
      write_row(`KERN_RD_LATENCY, 32'h0);
      write_row(`KERN_RRESP_ERR, 32'h0);
      foreach (zero_regs[ii]) begin
         if (zero_regs[ii] >= `KERN_WR_DONE_CNT_LO) begin
            read_row(zero_regs[ii], 32'h0, FULL);
         end
      end
   endtask

   // ============================================================
   // Table player
   // ============================================================
   task automatic apply_row(input row_t r);
      logic [31:0] rdata;
      string       name;
      name = $sformatf("o_cfg_rsp.rdata @0x%02h", r.addr);
      case (r.op)
         OP_WRITE: begin
            write_reg(r.addr, r.data);
            // Enable output follows bit 0 of the config register
            if (r.addr == `KERN_CFG) begin
               exp_enable = r.data[0];
            end
         end
         OP_READ: begin
            read_reg(r.addr, rdata);
            compare_val(name, rdata & r.mask, r.exp & r.mask);
         end
         OP_NONZERO: begin
            read_reg(r.addr, rdata);
            compare_val({name, " nonzero"}, 32'((rdata & r.mask) != 32'h0), 32'd1);
         end
         default: idle_cycles(int'(r.data));
      endcase
      compare_val("o_kernel_enable", 32'(kernel_enable), 32'(exp_enable));
   endtask

   initial begin
      cfg_req     = '0;
      rst_main_a0 = 1'b0;
      exp_enable  = 1'b0;
      build_table();
      // Reset held over two edges
      repeat (2) @(posedge clk_main_a0);
      #1;
      rst_main_a0 = 1'b1;
      foreach (rows[ii]) begin
         apply_row(rows[ii]);
      end
      $display("All tests passed");
      $finish;
   end

endmodule

// ==== kernel_top.f ====
+incdir+hdl
+incdir+testbench
hdl/kern_pkg.sv
hdl/pipe_delay.sv
hdl/scratch_mem.sv
hdl/wr_engine.sv
hdl/rd_engine.sv
hdl/kernel_regs.sv
hdl/kernel_top.sv
testbench/tb_kernel_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f kernel_top.f \
   --top-module tb_kernel_top -o sim_kernel

# A failed check ends the simulation with a nonzero status
output="$(./obj_dir/sim_kernel 2>&1 || true)"
echo "$output"

if echo "$output" | grep -qx "All tests passed"; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi
